//--- tb.f
+incdir+src
src/xbar_pkg.sv
src/switch_ctrl_store.sv
src/benes_network.sv
src/perm_router.sv
verif/perm_router_assertions.sv
verif/perm_router_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the perm_router testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f tb.f --top-module perm_router_tb \
    -o perm_router_sim > build.log 2>&1 \
    || { echo "Build failed, see build.log"; exit 1; }
# Assertion errors keep the run going so the summary is printed
./obj_dir/perm_router_sim +verilator+error+limit+100 > sim.log 2>&1
grep -qx "No errors" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed, see sim.log"; exit 1; }

//--- verif/perm_router_tb.sv
// Permutation router testbench
`include "xbar_defines.svh"

module perm_router_tb;

    import xbar_pkg::*;

    localparam int SIZE     = `XBAR_SIZE;
    localparam int DW       = `XBAR_DWIDTH;
    localparam int LW       = SIZE * DW;
    localparam int TAG      = `XBAR_TAGWIDTH;
    localparam int STAGES   = `XBAR_STAGES;
    localparam int CTRL     = `XBAR_CTRL_BITS;
    localparam int W        = `XBAR_CFG_WIDTH;
    localparam int AW       = `XBAR_CFG_AWIDTH;
    localparam int CHUNKS   = `XBAR_CFG_CHUNKS;
    localparam int CMD_ADDR = `XBAR_CFG_CMD_ADDR;
    localparam int LAT      = `XBAR_LATENCY;
    localparam int PAD      = CHUNKS * W - CTRL;     // Spare bits of the last chunk

    localparam int PERIOD     = 40;
    localparam int ITEM_SLOTS = 20 + 50 + 3 * 200 + 30 + 30 + 300;
    localparam int CFG_STEPS  = 48;                  // Config writes and idle checks

    logic          xif;
    logic          rst_n;
    logic          cfg_wr;
    logic [AW-1:0] cfg_addr;
    cfg_word_u     cfg_data;
    logic          in_valid;
    logic [LW-1:0] in_data;
    logic          out_valid;
    logic [LW-1:0] out_data;

    integer seed = 32'hf0d2_7079;

    // Host-side copy of the two banks
    logic [CTRL-1:0] model_shadow = '0;
    logic [CTRL-1:0] model_active = '0;

    logic [LW-1:0] exp_data_q [$];
    int            exp_due_q [$];                   // Negedge index of arrival

    int            errors = 0;
    int            checks = 0;
    int            cyc    = 0;
    logic          exp_vld;
    logic [LW-1:0] exp_data;

    initial xif = 1'b0;
    always #(PERIOD / 2) xif = ~xif;

    perm_router perm_router_i (
        .xif       (xif),
        .rst_n     (rst_n),
        .cfg_wr    (cfg_wr),
        .cfg_addr  (cfg_addr),
        .cfg_data  (cfg_data),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference model and stimulus helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic logic [LW-1:0] benes_model(input logic [LW-1:0]   din,
                                                  input logic [CTRL-1:0] ctrl);
        logic [SIZE-1:0][DW-1:0] v;
        logic [DW-1:0]           t;
        int                      d;
        int                      idx;
        int                      b;
        v = din;
        for (int s = 0; s < STAGES; s++) begin
            d = (s < TAG) ? (1 << s) : (1 << (2 * TAG - 2 - s));  // Mirrored after centre
            for (int grp = 0; grp < SIZE / (2 * d); grp++) begin
                for (int j = 0; j < d; j++) begin
                    idx = grp * 2 * d + j;
                    b   = s * SIZE / 2 - d * grp + idx;
                    if (ctrl[b]) begin
                        t          = v[idx];
                        v[idx]     = v[idx + d];
                        v[idx + d] = t;
                    end
                end
            end
        end
        return v;
    endfunction

    function automatic logic [LW-1:0] rand_lanes();
        logic [SIZE-1:0][DW-1:0] v;
        logic [31:0]             r;
        for (int i = 0; i < SIZE; i++) begin
            r    = $random(seed);
            v[i] = r[DW-1:0];
        end
        return v;
    endfunction

    function automatic logic [CTRL-1:0] rand_ctrl();
        logic [31:0] r;
        r = $random(seed);
        return r[CTRL-1:0];
    endfunction

    function automatic cfg_word_u chunk_word(input logic [CTRL-1:0] ctrl, input int n);
        logic [CHUNKS*W-1:0] padded;
        logic [31:0]         r;
        cfg_word_u           w;
        r       = $random(seed);
        padded  = {r[PAD-1:0], ctrl};   // Junk in the unused bits
        w.chunk = padded[n*W +: W];
        return w;
    endfunction

    function automatic cfg_word_u cmd_word(input logic commit, input logic clear);
        cfg_word_u w;
        w            = '0;
        w.cmd.commit = commit;
        w.cmd.clear  = clear;
        return w;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Compare tasks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic check_lanes(input logic [LW-1:0] got, input logic [LW-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error: out_data = %h, expected %h", got, exp);
        end
    endtask

    task automatic check_ctrl(input logic [CTRL-1:0] got, input logic [CTRL-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error: active_ctrl = %h, expected %h", got, exp);
        end
    endtask

    task automatic check_valid(input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error: out_valid = %h, expected %h", got, exp);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Driver
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // One cycle of config write and item with the host model kept in step
    task automatic step(input logic wr, input logic [AW-1:0] addr, input cfg_word_u data,
                        input logic vld, input logic [LW-1:0] din);
        logic [CHUNKS*W-1:0] padded;
        @(posedge xif);
        cfg_wr   <= wr;
        cfg_addr <= addr;
        cfg_data <= data;
        in_valid <= vld;
        in_data  <= din;
        if (vld) begin
            exp_data_q.push_back(benes_model(din, model_active));  // Old bank if commit now
            exp_due_q.push_back(cyc + 1 + LAT);
        end
        if (wr && int'(addr) < CHUNKS) begin
            padded                    = {{PAD{1'b0}}, model_shadow};
            padded[int'(addr)*W +: W] = data.chunk;
            model_shadow              = padded[CTRL-1:0];
        end else if (wr && int'(addr) == CMD_ADDR) begin
            if (data.cmd.commit) begin
                model_active = model_shadow;
            end
            if (data.cmd.clear) begin
                model_shadow = '0;
            end
        end
    endtask

    task automatic send_item(input logic [LW-1:0] din);
        step(1'b0, '0, '0, 1'b1, din);
    endtask

    task automatic idle_cycle();
        step(1'b0, '0, '0, 1'b0, '0);
    endtask

    task automatic write_cmd(input logic commit, input logic clear);
        step(1'b1, AW'(CMD_ADDR), cmd_word(commit, clear), 1'b0, '0);
    endtask

    task automatic write_chunks(input logic [CTRL-1:0] ctrl);
        for (int n = 0; n < CHUNKS; n++) begin
            step(1'b1, AW'(n), chunk_word(ctrl, n), 1'b0, '0);
        end
    endtask

    task automatic verify_active();
        idle_cycle();
        @(negedge xif);
        check_ctrl(perm_router_i.active_ctrl, model_active);
    endtask

    task automatic load_ctrl(input logic [CTRL-1:0] ctrl);
        write_chunks(ctrl);
        write_cmd(1'b1, 1'b0);
        verify_active();
    endtask

    task automatic drain();
        while (exp_due_q.size() > 0) begin
            idle_cycle();
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Output compare at mid-cycle
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        @(posedge xif);
        forever begin
            @(negedge xif);
            cyc++;
            exp_vld = (exp_due_q.size() > 0) && (exp_due_q[0] == cyc);
            check_valid(out_valid, exp_vld);
            if (exp_vld) begin
                exp_data = exp_data_q.pop_front();
                void'(exp_due_q.pop_front());
                if (out_valid) begin
                    check_lanes(out_data, exp_data);
                end
            end
        end
    end

    initial begin
        #((ITEM_SLOTS + CFG_STEPS + 100) * PERIOD);
        $display("Timeout: run did not finish, %0d items never came out, errors: %0d",
                 exp_due_q.size(), errors);
        $display("Errors found");
        $finish;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Test sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        logic [CTRL-1:0] ctrl;
        logic [31:0]     r;
        int              total;
        rst_n    = 1'b0;
        cfg_wr   = 1'b0;
        cfg_addr = '0;
        cfg_data = '0;
        in_valid = 1'b1;                        // Traffic offered during reset is dropped
        in_data  = rand_lanes();
        repeat (16) @(posedge xif);
        rst_n    <= 1'b1;
        in_valid <= 1'b0;
        in_data  <= '0;

        // Identity routing straight after reset
        verify_active();
        repeat (20) send_item(rand_lanes());
        drain();

        // Every switch crossed
        load_ctrl('1);
        repeat (50) send_item(rand_lanes());
        drain();

        repeat (3) begin
            load_ctrl(rand_ctrl());
            repeat (200) send_item(rand_lanes());
            drain();
        end

        // Chunks and commit while items stream back to back
        ctrl = rand_ctrl();
        for (int i = 0; i < 30; i++) begin
            if (i < CHUNKS) begin
                step(1'b1, AW'(i), chunk_word(ctrl, i), 1'b1, rand_lanes());
            end else if (i == 12) begin
                step(1'b1, AW'(CMD_ADDR), cmd_word(1'b1, 1'b0), 1'b1, rand_lanes());
            end else begin
                send_item(rand_lanes());
            end
        end
        drain();
        verify_active();

        // Shadow writes alone leave routing as it is
        ctrl = rand_ctrl();
        for (int i = 0; i < 10; i++) begin
            if (i < CHUNKS) begin
                step(1'b1, AW'(i), chunk_word(ctrl, i), 1'b1, rand_lanes());
            end else begin
                send_item(rand_lanes());
            end
        end
        drain();
        verify_active();
        write_cmd(1'b0, 1'b1);
        write_cmd(1'b1, 1'b0);
        verify_active();                        // Back to all zeroes
        repeat (10) send_item(rand_lanes());
        drain();

        // Combined command copies first, then clears
        write_chunks(ctrl);
        write_cmd(1'b1, 1'b1);
        verify_active();
        write_cmd(1'b1, 1'b0);
        verify_active();
        repeat (10) send_item(rand_lanes());
        drain();

        // Sparse valid
        load_ctrl(rand_ctrl());
        for (int i = 0; i < 300; i++) begin
            r = $random(seed);
            step(1'b0, '0, '0, r[3:2] != 2'b00, rand_lanes());
        end
        drain();
        repeat (4) idle_cycle();

        total = errors + perm_router_i.assertions_i.fail_count;
        $display("Checks: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, perm_router_i.assertions_i.fail_count);
        if (total == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- verif/perm_router_assertions.sv
// Router protocol checks
`include "xbar_defines.svh"

module perm_router_assertions (
    input logic                          xif,
    input logic                          rst_n,
    input logic                          cfg_wr,
    input logic [`XBAR_CFG_AWIDTH-1:0]   cfg_addr,
    input xbar_pkg::cfg_word_u           cfg_data,
    input logic [`XBAR_CTRL_BITS-1:0]    active_ctrl,
    input logic                          in_valid,
    input logic                          out_valid
);

    localparam int LAT = `XBAR_LATENCY;

    int   fail_count = 0;   // Failed assertions so far
    logic commit_cmd;

    assign commit_cmd = cfg_wr && (int'(cfg_addr) == `XBAR_CFG_CMD_ADDR)
                        && cfg_data.cmd.commit;

    // Valid goes through exactly LAT register stages
    if (LAT == 0) begin : comb_path
        a_valid_delay: assert property (@(posedge xif) out_valid == in_valid)
            else begin
                fail_count++;
                $error("out_valid does not follow in_valid");
            end
    end else begin : reg_path
        a_valid_delay: assert property (@(posedge xif) disable iff (!rst_n)
            $past(rst_n, LAT) |-> out_valid == $past(in_valid, LAT))
            else begin
                fail_count++;
                $error("out_valid is not in_valid delayed by %0d cycles", LAT);
            end
    end

    a_reset_quiet: assert property (@(posedge xif) !rst_n && $past(!rst_n) |-> !out_valid)
        else begin
            fail_count++;
            $error("out_valid high during reset");
        end

    // Active bank moves only on commit or reset
    a_ctrl_stable: assert property (@(posedge xif)
        (active_ctrl != $past(active_ctrl)) |-> $past(commit_cmd) || $past(!rst_n))
        else begin
            fail_count++;
            $error("active_ctrl changed without a commit");
        end

endmodule

bind perm_router perm_router_assertions assertions_i (
    .xif         (xif),
    .rst_n       (rst_n),
    .cfg_wr      (cfg_wr),
    .cfg_addr    (cfg_addr),
    .cfg_data    (cfg_data),
    .active_ctrl (active_ctrl),
    .in_valid    (in_valid),
    .out_valid   (out_valid)
);

//--- src/perm_router.sv
// Benes permutation router top
`include "xbar_defines.svh"

module perm_router (
    input  logic                                  xif,
    input  logic                                  rst_n,
    // Configuration write port
    input  logic                                  cfg_wr,
    input  logic [`XBAR_CFG_AWIDTH-1:0]           cfg_addr,
    input  xbar_pkg::cfg_word_u                   cfg_data,
    // Lane traffic
    input  logic                                  in_valid,
    input  logic [`XBAR_SIZE*`XBAR_DWIDTH-1:0]    in_data,
    output logic                                  out_valid,
    output logic [`XBAR_SIZE*`XBAR_DWIDTH-1:0]    out_data
);

    logic [`XBAR_CTRL_BITS-1:0] active_ctrl;   // Committed switch settings

    switch_ctrl_store ctrl_store_i (
        .xif         (xif),
        .rst_n       (rst_n),
        .cfg_wr      (cfg_wr),
        .cfg_addr    (cfg_addr),
        .cfg_data    (cfg_data),
        .active_ctrl (active_ctrl)
    );

    benes_network network_i (
        .xif         (xif),
        .rst_n       (rst_n),
        .active_ctrl (active_ctrl),
        .in_valid    (in_valid),
        .in_data     (in_data),
        .out_valid   (out_valid),
        .out_data    (out_data)
    );

endmodule

//--- src/benes_network.sv
// Pipelined Benes switch fabric
`include "xbar_defines.svh"

module benes_network (
    input  logic                                  xif,
    input  logic                                  rst_n,
    input  logic [`XBAR_CTRL_BITS-1:0]            active_ctrl,
    input  logic                                  in_valid,
    input  logic [`XBAR_SIZE*`XBAR_DWIDTH-1:0]    in_data,
    output logic                                  out_valid,
    output logic [`XBAR_SIZE*`XBAR_DWIDTH-1:0]    out_data
);

    localparam int SIZE     = `XBAR_SIZE;
    localparam int DWIDTH   = `XBAR_DWIDTH;
    localparam int TAGWIDTH = `XBAR_TAGWIDTH;
    localparam int STAGES   = `XBAR_STAGES;
    localparam int HALF     = SIZE / 2;         // Switches per column
    localparam int BITWIDTH = `XBAR_CTRL_BITS;

    // Register after column s
    localparam logic [STAGES-2:0] REG_AT = `XBAR_REGISTER_MASK;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Switch columns
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    for (genvar s = 0; s < STAGES; s++) begin : col
        // Pair distance doubles up to the centre column, then halves
        localparam int D  = (s < TAGWIDTH) ? (1 << s) : (1 << (STAGES - 1 - s));
        localparam int LO = s * HALF;           // First control bit of this column

        logic [SIZE-1:0][DWIDTH-1:0] lane_in;
        logic [SIZE-1:0][DWIDTH-1:0] lane_out;
        logic                        vld_in;
        logic [BITWIDTH-1:LO]        ctrl_in;   // This column and all later ones
        logic [HALF-1:0]             sel;

        assign sel = ctrl_in[LO +: HALF];

        // Column input comes from the ports, a boundary register or straight
        // from the previous column
        if (s == 0) begin : from_port
            assign lane_in = in_data;
            assign vld_in  = in_valid;
            assign ctrl_in = active_ctrl;
        end else if (REG_AT[s-1]) begin : from_reg
            logic [SIZE-1:0][DWIDTH-1:0] lane_q;
            logic                        vld_q;
            logic [BITWIDTH-1:LO]        ctrl_q;   // Bits already consumed are dropped

            always_ff @(posedge xif) begin
                if (!rst_n) begin
                    lane_q <= '0;
                    vld_q  <= 1'b0;
                    ctrl_q <= '0;
                end else begin
                    lane_q <= col[s-1].lane_out;
                    vld_q  <= col[s-1].vld_in;
                    ctrl_q <= col[s-1].ctrl_in[BITWIDTH-1:LO];
                end
            end

            assign lane_in = lane_q;
            assign vld_in  = vld_q;
            assign ctrl_in = ctrl_q;
        end else begin : from_col
            assign lane_in = col[s-1].lane_out;
            assign vld_in  = col[s-1].vld_in;
            assign ctrl_in = col[s-1].ctrl_in[BITWIDTH-1:LO];
        end

        // 2x2 crossover of lanes A and A+D crossed by a set bit
        for (genvar g = 0; g < HALF / D; g++) begin : grp
            for (genvar j = 0; j < D; j++) begin : sw
                localparam int A = g * 2 * D + j;   // Upper lane of the pair
                localparam int K = g * D + j;       // Bit within the column

                assign lane_out[A]     = sel[K] ? lane_in[A + D] : lane_in[A];
                assign lane_out[A + D] = sel[K] ? lane_in[A]     : lane_in[A + D];
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Outputs
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign out_data  = col[STAGES-1].lane_out;
    assign out_valid = col[STAGES-1].vld_in;   // Last column is never registered

endmodule

//--- src/switch_ctrl_store.sv
// Switch control shadow and active banks
`include "xbar_defines.svh"

module switch_ctrl_store (
    input  logic                          xif,
    input  logic                          rst_n,
    input  logic                          cfg_wr,
    input  logic [`XBAR_CFG_AWIDTH-1:0]   cfg_addr,
    input  xbar_pkg::cfg_word_u           cfg_data,
    output logic [`XBAR_CTRL_BITS-1:0]    active_ctrl
);

    localparam int W     = `XBAR_CFG_WIDTH;
    localparam int NBITS = `XBAR_CTRL_BITS;

    logic             chunk_wr;      // Write to a control chunk
    logic             cmd_wr;        // Write to the command word
    logic             do_commit;
    logic             do_clear;
    logic [NBITS-1:0] shadow_ctrl;
    logic [NBITS-1:0] shadow_next;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Address decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        chunk_wr  = cfg_wr && (cfg_addr < `XBAR_CFG_CHUNKS);
        cmd_wr    = cfg_wr && (cfg_addr == `XBAR_CFG_CMD_ADDR);
        do_commit = cmd_wr && cfg_data.cmd.commit;
        do_clear  = cmd_wr && cfg_data.cmd.clear;
    end

    // Merge a chunk into the shadow bank.
    // Looping over control bits leaves the spare top bits of the last chunk unused.
    always_comb begin
        shadow_next = shadow_ctrl;
        for (int b = 0; b < NBITS; b++) begin
            if (chunk_wr && ((b / W) == int'(cfg_addr))) begin
                shadow_next[b] = cfg_data.chunk[b % W];
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Banks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge xif) begin
        if (!rst_n) begin
            shadow_ctrl <= '0;
        end else if (do_clear) begin
            shadow_ctrl <= '0;          // Commit below still sees the old shadow
        end else begin
            shadow_ctrl <= shadow_next;
        end
    end

    // Active bank feeds the network, identity after reset
    always_ff @(posedge xif) begin
        if (!rst_n) begin
            active_ctrl <= '0;
        end else if (do_commit) begin
            active_ctrl <= shadow_ctrl;
        end
    end

endmodule

//--- src/xbar_pkg.sv
// Crossbar configuration types
`include "xbar_defines.svh"

package xbar_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Configuration word
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Chunk addresses carry control bits, the command address carries flags.
    // Chunk n holds control bits n*CFG_WIDTH upward, LSB first.
    typedef union packed {
        logic [`XBAR_CFG_WIDTH-1:0] chunk;       // Raw switch bits
        struct packed {
            logic                       commit;  // Shadow to active
            logic                       clear;   // Zero the shadow
            logic [`XBAR_CFG_WIDTH-3:0] reserved;
        } cmd;
    } cfg_word_u;

endpackage

//--- src/xbar_defines.svh
// Crossbar sizing and configuration layout
`ifndef XBAR_DEFINES_SVH
`define XBAR_DEFINES_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Network geometry
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define XBAR_SIZE           8                                   // Lanes, power of two
`define XBAR_DWIDTH         16                                  // Bits per lane
`define XBAR_TAGWIDTH       3                                   // log2 of lanes
`define XBAR_STAGES         (2 * `XBAR_TAGWIDTH - 1)            // Switch columns
`define XBAR_CTRL_BITS      (`XBAR_STAGES * `XBAR_SIZE / 2)     // One bit per switch

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Pipelining
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bit s puts a register after column s, last column never registered
`define XBAR_REGISTER_MASK  4'b0101
`define XBAR_LATENCY        2                                   // Set bits in the mask

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Configuration port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define XBAR_CFG_WIDTH      8
`define XBAR_CFG_CHUNKS     ((`XBAR_CTRL_BITS + `XBAR_CFG_WIDTH - 1) / `XBAR_CFG_WIDTH)
`define XBAR_CFG_AWIDTH     2
`define XBAR_CFG_CMD_ADDR   (`XBAR_CFG_CHUNKS)                  // Word after the last chunk

`endif
